// File: include/codec_init_settings.svh
`ifndef CODEC_INIT_SETTINGS_SVH
`define CODEC_INIT_SETTINGS_SVH

// Frame geometry and sequence length
`define CI_FRAME_BITS 28
`define CI_NUM_WRITES 7

// Codec write address, 7-bit address 0x1A plus R/W = 0
`define CI_DEV_ADDR 8'h34

// Register words as {reg_addr[6:0], data[8:0]}, sent in this order
`define CI_WR_RESET        16'h1E00
`define CI_WR_ANALOG_PATH  16'h0815
`define CI_WR_DIGITAL_PATH 16'h0A00
`define CI_WR_POWER        16'h0C00
`define CI_WR_FORMAT       16'h0E42
`define CI_WR_SAMPLING     16'h1019
`define CI_WR_ACTIVE       16'h1201

`endif

// File: hw/codec_init_pkg.sv
`default_nettype none

`include "codec_init_settings.svh"

package codec_init_pkg;

    typedef logic [2:0] ci_write_idx_t;  // Position in the write list
    typedef logic [4:0] ci_bit_idx_t;    // Bit position inside one frame

    // One two-wire frame, shifted out MSB first
    typedef union packed {
        logic [`CI_FRAME_BITS-1:0] raw;
        struct packed {
            logic [7:0] dev_addr;
            logic       ack0;       // Released for the codec
            logic [6:0] reg_addr;
            logic       data_hi;
            logic       ack1;
            logic [7:0] data_lo;
            logic       ack2;
            logic       stop_pad;   // Keeps SDA low ahead of the stop
        } fields;
    } ci_frame_u;

endpackage

`default_nettype wire

// File: hw/init_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "codec_init_settings.svh"

module init_sequencer import codec_init_pkg::*; (
    input  wire       i_clk,
    input  wire       i_rst_n,
    input  wire       i_start,
    input  wire       i_frame_done,
    output ci_frame_u o_frame,
    output logic      o_load,
    output logic      o_first,
    output logic      o_finished
);

    localparam ci_write_idx_t LAST_WRITE = ci_write_idx_t'(`CI_NUM_WRITES - 1);

    logic          start_d;
    logic          start_edge;
    logic          busy_r;
    ci_write_idx_t idx_r;
    logic [15:0]   reg_word;

    assign start_edge = i_start & ~start_d;  // Rising edge only

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            start_d    <= 1'b0;
            busy_r     <= 1'b0;
            idx_r      <= '0;
            o_load     <= 1'b0;
            o_first    <= 1'b0;
            o_finished <= 1'b0;
        end else begin
            start_d <= i_start;
            o_load  <= 1'b0;
            o_first <= 1'b0;
            if (start_edge && !busy_r) begin
                busy_r     <= 1'b1;
                o_finished <= 1'b0;
                idx_r      <= '0;
                o_load     <= 1'b1;
                o_first    <= 1'b1;
            end else if (busy_r && i_frame_done) begin
                if (idx_r == LAST_WRITE) begin
                    busy_r     <= 1'b0;
                    o_finished <= 1'b1;  // Held until the next start edge
                end else begin
                    idx_r  <= idx_r + 3'd1;
                    o_load <= 1'b1;      // Back to back with frame_done
                end
            end
        end
    end

    // Write table
    always_comb begin
        case (idx_r)
            3'd0:    reg_word = `CI_WR_RESET;
            3'd1:    reg_word = `CI_WR_ANALOG_PATH;
            3'd2:    reg_word = `CI_WR_DIGITAL_PATH;
            3'd3:    reg_word = `CI_WR_POWER;
            3'd4:    reg_word = `CI_WR_FORMAT;
            3'd5:    reg_word = `CI_WR_SAMPLING;
            default: reg_word = `CI_WR_ACTIVE;
        endcase
    end

    // Frame assembly, stable while idx_r holds
    always_comb begin
        o_frame.fields.dev_addr = `CI_DEV_ADDR;
        o_frame.fields.ack0     = 1'b1;
        o_frame.fields.reg_addr = reg_word[15:9];
        o_frame.fields.data_hi  = reg_word[8];
        o_frame.fields.ack1     = 1'b1;
        o_frame.fields.data_lo  = reg_word[7:0];
        o_frame.fields.ack2     = 1'b1;
        o_frame.fields.stop_pad = 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/i2c_frame_shifter.sv
`timescale 1ns/10ps
`default_nettype none

`include "codec_init_settings.svh"

module i2c_frame_shifter import codec_init_pkg::*; (
    input  wire       i_clk,
    input  wire       i_rst_n,
    input  ci_frame_u i_frame,
    input  wire       i_load,
    input  wire       i_first,
    output logic      o_scl,
    output logic      o_sda,
    output logic      o_ack_slot,
    output logic      o_frame_done,
    output logic      o_seq_begin
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_PREP    = 3'd1;
    localparam logic [2:0] S_HIGH    = 3'd2;
    localparam logic [2:0] S_LOW     = 3'd3;
    localparam logic [2:0] S_RELEASE = 3'd4;
    localparam logic [2:0] S_DONE    = 3'd5;

    localparam ci_bit_idx_t LAST_BIT = ci_bit_idx_t'(`CI_FRAME_BITS - 1);

    // Acknowledge bit positions, counted from the MSB
    localparam ci_bit_idx_t ACK_POS0 = 5'd8;
    localparam ci_bit_idx_t ACK_POS1 = 5'd17;
    localparam ci_bit_idx_t ACK_POS2 = 5'd26;

    logic [2:0]  state_r;
    ci_bit_idx_t bit_cnt_r;
    ci_bit_idx_t raw_sel;
    logic        cur_bit;
    logic        in_ack_pos;

    assign raw_sel    = LAST_BIT - bit_cnt_r;
    assign cur_bit    = i_frame.raw[raw_sel];
    assign in_ack_pos = (bit_cnt_r == ACK_POS0) || (bit_cnt_r == ACK_POS1) ||
                        (bit_cnt_r == ACK_POS2);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r   <= S_IDLE;
            bit_cnt_r <= '0;
        end else begin
            case (state_r)
                S_IDLE: begin
                    if (i_load) begin
                        state_r   <= S_PREP;
                        bit_cnt_r <= '0;
                    end
                end
                S_PREP:  state_r <= S_HIGH;
                S_HIGH: begin
                    if (bit_cnt_r == LAST_BIT) begin
                        state_r <= S_RELEASE;
                    end else begin
                        state_r   <= S_LOW;
                        bit_cnt_r <= bit_cnt_r + 5'd1;  // Next bit set up in low phase
                    end
                end
                S_LOW:     state_r <= S_HIGH;
                S_RELEASE: state_r <= S_DONE;
                S_DONE:    state_r <= S_IDLE;
                default:   state_r <= S_IDLE;
            endcase
        end
    end

    // Bus levels per state
    always_comb begin
        o_scl = 1'b1;
        o_sda = 1'b1;
        case (state_r)
            S_IDLE: o_sda = ~i_load;  // Start condition, SDA drops with SCL high
            S_PREP: begin
                o_scl = 1'b0;
                o_sda = cur_bit;
            end
            S_HIGH: o_sda = cur_bit;
            S_LOW: begin
                o_scl = 1'b0;
                o_sda = cur_bit;
            end
            default: ;  // Stop and idle, both lines high
        endcase
    end

    assign o_ack_slot   = ((state_r == S_HIGH) || (state_r == S_LOW)) && in_ack_pos;
    assign o_frame_done = (state_r == S_DONE);
    assign o_seq_begin  = (state_r == S_IDLE) && i_load && i_first;

endmodule

`default_nettype wire

// File: hw/i2c_line_driver.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_line_driver (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_scl,
    input  wire  i_sda,
    input  wire  i_ack_slot,
    input  wire  i_seq_begin,
    input  wire  i_sdat,
    output logic o_sclk,
    output logic o_sdat,
    output logic o_oen,
    output logic o_nack
);

    logic sclk_d;     // Previous bus clock level
    logic scl_rise;

    // First cycle of a high phase on the bus
    assign scl_rise = o_sclk & ~sclk_d;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            o_sclk <= 1'b1;
            o_sdat <= 1'b1;
            o_oen  <= 1'b1;
            sclk_d <= 1'b1;
        end else begin
            o_sclk <= i_scl;
            o_sdat <= i_sda;
            o_oen  <= ~i_ack_slot;  // Codec owns SDA in ack slots
            sclk_d <= o_sclk;
        end
    end

    // Sticky nack, cleared when a new sequence begins
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            o_nack <= 1'b0;
        end else if (i_seq_begin) begin
            o_nack <= 1'b0;
        end else if (scl_rise && !o_oen && i_sdat) begin
            o_nack <= 1'b1;  // Line left high by the codec
        end
    end

endmodule

`default_nettype wire

// File: hw/codec_init_top.sv
`timescale 1ns/10ps
`default_nettype none

module codec_init_top import codec_init_pkg::*; (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_start,
    input  wire  i_sdat,
    output logic o_sclk,
    output logic o_sdat,
    output logic o_oen,
    output logic o_finished,
    output logic o_nack
);

    ci_frame_u frame;
    logic      load;
    logic      first;
    logic      frame_done;
    logic      scl;
    logic      sda;
    logic      ack_slot;
    logic      seq_begin;

    // Write list walk and frame build
    init_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_frame_done (frame_done),
        .o_frame      (frame),
        .o_load       (load),
        .o_first      (first),
        .o_finished   (o_finished)
    );

    i2c_frame_shifter u_shifter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame      (frame),
        .i_load       (load),
        .i_first      (first),
        .o_scl        (scl),
        .o_sda        (sda),
        .o_ack_slot   (ack_slot),
        .o_frame_done (frame_done),
        .o_seq_begin  (seq_begin)
    );

    // Bus side registers and nack capture
    i2c_line_driver u_line_driver (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_scl       (scl),
        .i_sda       (sda),
        .i_ack_slot  (ack_slot),
        .i_seq_begin (seq_begin),
        .i_sdat      (i_sdat),
        .o_sclk      (o_sclk),
        .o_sdat      (o_sdat),
        .o_oen       (o_oen),
        .o_nack      (o_nack)
    );

endmodule

`default_nettype wire

// File: bench/i2c_codec_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "codec_init_settings.svh"

module i2c_codec_model import codec_init_pkg::*; (
    input  wire                       i_clk,
    input  wire                       i_rst_n,       // Active high
    input  wire                       i_sclk,
    input  wire                       i_sdat,
    input  wire                       i_oen,
    input  int                        i_nack_frame,  // Frame index left unacknowledged
    output logic                      o_sdat,
    output ci_frame_u                 o_frame,
    output logic [`CI_FRAME_BITS-1:0] o_ack_mask,
    output int                        o_frame_count,
    output int                        o_edge_count
);

    logic                      sclk_q;
    logic                      sdat_q;
    ci_frame_u                 shift_r;
    logic [`CI_FRAME_BITS-1:0] mask_r;
    int                        bit_cnt;

    // Pulled up unless acknowledging the current frame
    assign o_sdat = i_oen | (o_frame_count == i_nack_frame);

    // Bus sampled mid-cycle, away from the DUT register updates
    always @(negedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            sclk_q        <= 1'b1;
            sdat_q        <= 1'b1;
            shift_r       <= '0;
            mask_r        <= '0;
            bit_cnt       <= 0;
            o_frame       <= '0;
            o_ack_mask    <= '0;
            o_frame_count <= 0;
            o_edge_count  <= 0;
        end else begin
            sclk_q <= i_sclk;
            sdat_q <= i_sdat;
            if (i_sclk && sclk_q && sdat_q && !i_sdat && i_oen) begin
                bit_cnt <= 0;  // Start condition
            end else if (i_sclk && !sclk_q) begin
                o_edge_count <= o_edge_count + 1;
                shift_r.raw  <= {shift_r.raw[`CI_FRAME_BITS-2:0], i_sdat};
                mask_r       <= {mask_r[`CI_FRAME_BITS-2:0], ~i_oen};  // Released bits
                bit_cnt      <= bit_cnt + 1;
                if (bit_cnt == `CI_FRAME_BITS - 1) begin
                    o_frame.raw   <= {shift_r.raw[`CI_FRAME_BITS-2:0], i_sdat};
                    o_ack_mask    <= {mask_r[`CI_FRAME_BITS-2:0], ~i_oen};
                    o_frame_count <= o_frame_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/codec_init_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "codec_init_settings.svh"

module codec_init_tb import codec_init_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 6 * `CI_NUM_WRITES * 58 + 500;

    logic                      clk;
    logic                      rst;        // Active high
    logic                      start;
    logic                      ack_line;
    logic                      sclk;
    logic                      sdat;
    logic                      oen;
    logic                      finished;
    logic                      nack;
    ci_frame_u                 cap_frame;
    logic [`CI_FRAME_BITS-1:0] cap_mask;
    int                        frame_count;
    int                        edge_count;
    int                        nack_frame;
    int                        errors;
    int                        failed_tests;
    int                        cycles = 0;

    // Codec register words in send order
    logic [15:0] words [0:`CI_NUM_WRITES-1] = '{16'h1E00, 16'h0815, 16'h0A00,
                                               16'h0C00, 16'h0E42, 16'h1019, 16'h1201};

    codec_init_top dut (
        .i_clk      (clk),
        .i_rst_n    (rst),
        .i_start    (start),
        .i_sdat     (ack_line),
        .o_sclk     (sclk),
        .o_sdat     (sdat),
        .o_oen      (oen),
        .o_finished (finished),
        .o_nack     (nack)
    );

    i2c_codec_model codec (
        .i_clk         (clk),
        .i_rst_n       (rst),
        .i_sclk        (sclk),
        .i_sdat        (sdat),
        .i_oen         (oen),
        .i_nack_frame  (nack_frame),
        .o_sdat        (ack_line),
        .o_frame       (cap_frame),
        .o_ack_mask    (cap_mask),
        .o_frame_count (frame_count),
        .o_edge_count  (edge_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // Address byte, released ack bits, stop bit low
    function automatic ci_frame_u expected_frame(input logic [15:0] word);
        ci_frame_u f;
        f.raw = {8'h34, 1'b1, word[15:9], word[8], 1'b1, word[7:0], 1'b1, 1'b0};
        return f;
    endfunction

    function automatic logic [`CI_FRAME_BITS-1:0] expected_mask();
        logic [`CI_FRAME_BITS-1:0] m;
        int                        p;
        m = '0;
        for (p = 8; p < `CI_FRAME_BITS; p += 9) begin
            m[`CI_FRAME_BITS-1-p] = 1'b1;  // Every ninth bit from the MSB
        end
        return m;
    endfunction

    task automatic check_frame(input string name, input ci_frame_u exp, input ci_frame_u act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp.raw, act.raw);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input logic [`CI_FRAME_BITS-1:0] exp,
                              input logic [`CI_FRAME_BITS-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic pulse_start();
        wait_cycles(1);
        start = 1'b0;
        wait_cycles(1);
        start = 1'b1;  // Held high afterwards
        wait_cycles(1);
    endtask

    // Checks every frame from index first as it arrives, then the finished level
    task automatic collect_sequence(input int base, input int first, input bit with_masks);
        int k;
        int n;
        for (k = first; k < `CI_NUM_WRITES; k++) begin
            while (frame_count <= base + k) @(negedge clk);
            check_frame($sformatf("frame[%0d]", k), expected_frame(words[k]), cap_frame);
            if (with_masks) begin
                check_mask($sformatf("ack_mask[%0d]", k), expected_mask(), cap_mask);
            end
        end
        n = 0;
        while (!finished && n < 4) begin
            @(negedge clk);
            n++;
        end
        check_bit("o_finished", 1'b1, finished);
        check_count("frame_count", base + `CI_NUM_WRITES, frame_count);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
            failed_tests++;
        end
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        wait_cycles(10);
        @(negedge clk);
        check_bit("o_sclk", 1'b1, sclk);
        check_bit("o_sdat", 1'b1, sdat);
        check_bit("o_oen", 1'b1, oen);
        check_bit("o_finished", 1'b0, finished);
        check_bit("o_nack", 1'b0, nack);
        check_count("scl_edges", 0, edge_count);
        end_test("reset", e);
    endtask

    task automatic test_sequence();
        int e;
        e = errors;
        pulse_start();
        collect_sequence(0, 0, 1'b0);
        end_test("sequence", e);
    endtask

    task automatic test_finish();
        int e;
        int edges;
        e = errors;
        edges = edge_count;
        wait_cycles(100);  // Start still held high
        @(negedge clk);
        check_bit("o_finished", 1'b1, finished);
        check_count("scl_edges", edges, edge_count);
        end_test("finish", e);
    endtask

    task automatic test_ack();
        int e;
        e = errors;
        pulse_start();
        collect_sequence(frame_count, 0, 1'b1);
        check_bit("o_nack", 1'b0, nack);
        end_test("ack", e);
    endtask

    task automatic test_nack();
        int e;
        e = errors;
        nack_frame = frame_count + 2;  // Third frame of the sequence
        pulse_start();
        collect_sequence(frame_count, 0, 1'b0);
        check_bit("o_nack", 1'b1, nack);
        nack_frame = -1;
        pulse_start();
        wait_cycles(1);
        @(negedge clk);
        check_bit("o_finished", 1'b0, finished);
        check_bit("o_nack", 1'b0, nack);
        collect_sequence(frame_count, 0, 1'b0);
        end_test("nack", e);
    endtask

    task automatic test_restart();
        int e;
        int base;
        int edges;
        e = errors;
        pulse_start();
        base = frame_count;
        while (frame_count <= base) @(negedge clk);
        check_frame("frame[0]", expected_frame(words[0]), cap_frame);
        pulse_start();  // Lands mid-sequence
        collect_sequence(base, 1, 1'b0);
        edges = edge_count;
        wait_cycles(60);
        @(negedge clk);
        check_count("scl_edges", edges, edge_count);
        check_count("frame_count", base + `CI_NUM_WRITES, frame_count);
        end_test("restart", e);
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        nack_frame   = -1;
        errors       = 0;
        failed_tests = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_sequence();
        test_finish();
        test_ack();
        test_nack();
        test_restart();
        $display("Tests run: 6, failed: %0d, check errors: %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
hw/codec_init_pkg.sv
hw/init_sequencer.sv
hw/i2c_frame_shifter.sv
hw/i2c_line_driver.sv
hw/codec_init_top.sv
bench/i2c_codec_model.sv
bench/codec_init_tb.sv

// File: Makefile
# Verilator flow for the codec init testbench

VERILATOR  ?= verilator
TOP        ?= codec_init_tb
FILELIST   ?= compile.f
FLAGS      ?= --timing
LINT_FLAGS ?= -Wall --timing
OBJ_DIR    ?= obj_dir
PASS_TEXT  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status comes from the search for the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
